/* rtl/conv_link_pkg.sv */
package conv_link_pkg;

    // Bit periods per link frame
    parameter int FRAME_BITS = 8;

    // Converter ports on the isolated audio bus
    parameter int NUM_PORTS = 4;

    // Parallel contents of one link frame
    typedef logic [FRAME_BITS-1:0] frame_word_t;

    // One bit per converter port
    typedef logic [NUM_PORTS-1:0] port_mask_t;

    // Configuration register addresses
    typedef enum logic [2:0] {
        REG_HWCON0 = 3'd0,
        REG_HWCON1 = 3'd1,
        REG_HWCON2 = 3'd2,
        REG_HWCON3 = 3'd3,
        REG_CLKSEL = 3'd4
    } cfg_reg_e;

    // Single-cycle write strobe into the register file
    typedef struct packed {
        logic        write;
        cfg_reg_e    addr;
        frame_word_t data;
    } cfg_write_t;

    // Status bits returned over the link
    typedef struct packed {
        // Channel order from MSB: R3 L3 R2 L2 R1 L1 R0 L0
        frame_word_t adc_ovf;
        // 0 = 2-channel, 1 = 8-channel
        port_mask_t  num_channels;
        // 0 = DAC, 1 = ADC
        port_mask_t  direction;
    } port_status_t;

endpackage

/* rtl/link_frame_timer.sv */
`timescale 1ns/1ps

module link_frame_timer #(
    parameter int FRAME_BITS = conv_link_pkg::FRAME_BITS
) (
    input  logic       custom_srclk,
    input  logic       reset,
    output logic       frame_load,
    output logic [1:0] hwcon_index
);

    localparam int CNT_W = $clog2(FRAME_BITS);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(FRAME_BITS - 1);

    logic [CNT_W-1:0] bit_count;

    // Free-running bit counter, wraps at the end of each frame
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            bit_count <= '0;
        end else if (bit_count == LAST_BIT) begin
            bit_count <= '0;
        end else begin
            bit_count <= bit_count + 1'b1;
        end
    end

    // Boundary strobe follows the last bit of the frame by one cycle
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            frame_load <= 1'b0;
        end else begin
            frame_load <= (bit_count == LAST_BIT);
        end
    end

    // One configuration byte per frame, rotating over the ports
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            hwcon_index <= 2'd0;
        end else if (frame_load) begin
            hwcon_index <= hwcon_index + 2'd1;
        end
    end

endmodule

/* rtl/link_serializer.sv */
`timescale 1ns/1ps

module link_serializer #(
    parameter int                        FRAME_BITS = conv_link_pkg::FRAME_BITS,
    parameter conv_link_pkg::frame_word_t RESET_WORD = '0
) (
    input  logic                        custom_srclk,
    input  logic                        reset,
    input  logic                        frame_load,
    input  conv_link_pkg::frame_word_t  word,
    output logic                        serial
);

    // Line level while nothing has been loaded yet
    localparam logic IDLE_BIT = RESET_WORD[FRAME_BITS-1];

    logic [FRAME_BITS-1:0] shift_reg;

    // Parallel load on the frame boundary, otherwise shift left
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            shift_reg <= RESET_WORD;
        end else if (frame_load) begin
            shift_reg <= word;
        end else begin
            // Idle level fills in behind the outgoing bits
            shift_reg <= {shift_reg[FRAME_BITS-2:0], IDLE_BIT};
        end
    end

    // MSB goes out first
    assign serial = shift_reg[FRAME_BITS-1];

endmodule

/* rtl/link_deserializer.sv */
`timescale 1ns/1ps

module link_deserializer #(
    parameter int FRAME_BITS = conv_link_pkg::FRAME_BITS
) (
    input  logic                        custom_srclk,
    input  logic                        reset,
    input  logic                        frame_load,
    input  logic                        serial,
    output conv_link_pkg::frame_word_t  word
);

    logic [FRAME_BITS-1:0] shift_reg;

    // Newest sample enters at the LSB on every edge
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            shift_reg <= '0;
        end else begin
            shift_reg <= {shift_reg[FRAME_BITS-2:0], serial};
        end
    end

    // Capture the previous frame, earliest bit ends up as MSB
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            word <= '0;
        end else if (frame_load) begin
            word <= shift_reg;
        end
    end

endmodule

/* rtl/port_config_regs.sv */
`timescale 1ns/1ps

module port_config_regs (
    input  logic                        custom_srclk,
    input  logic                        reset,
    input  conv_link_pkg::cfg_write_t   cfg,
    input  logic [1:0]                  hwcon_index,
    output conv_link_pkg::port_mask_t   clksel,
    output conv_link_pkg::frame_word_t  hwcon_byte
);

    localparam int NP = conv_link_pkg::NUM_PORTS;

    // Hardware configuration byte per port
    conv_link_pkg::frame_word_t hwcon [NP];

    // Clock select register, 0 = 11.2896 MHz, 1 = 24.576 MHz per port
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            clksel <= '0;
        end else if (cfg.write && cfg.addr == conv_link_pkg::REG_CLKSEL) begin
            // Only the low nibble maps to ports
            clksel <= cfg.data[NP-1:0];
        end
    end

    // Configuration bytes, one address per port
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NP; i++) begin
                hwcon[i] <= '0;
            end
        end else if (cfg.write) begin
            case (cfg.addr)
                conv_link_pkg::REG_HWCON0: begin
                    hwcon[0] <= cfg.data;
                end
                conv_link_pkg::REG_HWCON1: begin
                    hwcon[1] <= cfg.data;
                end
                conv_link_pkg::REG_HWCON2: begin
                    hwcon[2] <= cfg.data;
                end
                conv_link_pkg::REG_HWCON3: begin
                    hwcon[3] <= cfg.data;
                end
                default: begin
                    // Clock select and unused addresses leave the bytes alone
                end
            endcase
        end
    end

    // Byte for the current frame, sampled by the serializer on load
    assign hwcon_byte = hwcon[hwcon_index];

endmodule

/* rtl/converter_link_top.sv */
`timescale 1ns/1ps

module converter_link_top #(
    parameter int FRAME_BITS = conv_link_pkg::FRAME_BITS
) (
    input  logic                         custom_srclk,
    input  logic                         reset,
    input  conv_link_pkg::cfg_write_t    cfg,
    input  conv_link_pkg::port_mask_t    spi_adc_sel,
    input  conv_link_pkg::port_mask_t    spi_dac_sel,
    input  logic                         custom_adc_ovf,
    input  logic                         custom_dirchan,
    output logic                         frame_load,
    output logic                         spi_adc_cs,
    output logic                         spi_dac_cs,
    output logic                         custom_clksel,
    output logic                         custom_adc_hwcon,
    output conv_link_pkg::port_status_t  port_status
);

    localparam int NP = conv_link_pkg::NUM_PORTS;
    localparam int PAD_BITS = $bits(conv_link_pkg::frame_word_t) - NP;

    logic [1:0]                  hwcon_index;
    conv_link_pkg::port_mask_t   clksel;
    conv_link_pkg::frame_word_t  hwcon_byte;
    conv_link_pkg::frame_word_t  adc_cs_word;
    conv_link_pkg::frame_word_t  dac_cs_word;
    conv_link_pkg::frame_word_t  clksel_word;
    conv_link_pkg::frame_word_t  ovf_word;
    conv_link_pkg::frame_word_t  dirchan_word;

    link_frame_timer #(.FRAME_BITS(FRAME_BITS)) i_timer (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_load   (frame_load),
        .hwcon_index  (hwcon_index)
    );

    port_config_regs i_regs (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .cfg          (cfg),
        .hwcon_index  (hwcon_index),
        .clksel       (clksel),
        .hwcon_byte   (hwcon_byte)
    );

    // Chip selects are active low, unused upper bits stay high
    assign adc_cs_word = ~{{PAD_BITS{1'b0}}, spi_adc_sel};
    assign dac_cs_word = ~{{PAD_BITS{1'b0}}, spi_dac_sel};
    assign clksel_word = {{PAD_BITS{1'b0}}, clksel};

    link_serializer #(.FRAME_BITS(FRAME_BITS), .RESET_WORD('1)) i_ser_adc_cs (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_load   (frame_load),
        .word         (adc_cs_word),
        .serial       (spi_adc_cs)
    );

    link_serializer #(.FRAME_BITS(FRAME_BITS), .RESET_WORD('1)) i_ser_dac_cs (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_load   (frame_load),
        .word         (dac_cs_word),
        .serial       (spi_dac_cs)
    );

    link_serializer #(.FRAME_BITS(FRAME_BITS), .RESET_WORD('0)) i_ser_clksel (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_load   (frame_load),
        .word         (clksel_word),
        .serial       (custom_clksel)
    );

    link_serializer #(.FRAME_BITS(FRAME_BITS), .RESET_WORD('0)) i_ser_hwcon (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_load   (frame_load),
        .word         (hwcon_byte),
        .serial       (custom_adc_hwcon)
    );

    link_deserializer #(.FRAME_BITS(FRAME_BITS)) i_deser_ovf (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_load   (frame_load),
        .serial       (custom_adc_ovf),
        .word         (ovf_word)
    );

    link_deserializer #(.FRAME_BITS(FRAME_BITS)) i_deser_dirchan (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_load   (frame_load),
        .serial       (custom_dirchan),
        .word         (dirchan_word)
    );

    // Channel count in the high nibble, direction in the low nibble
    assign port_status.adc_ovf      = ovf_word;
    assign port_status.num_channels = dirchan_word[2*NP-1:NP];
    assign port_status.direction    = dirchan_word[NP-1:0];

endmodule

/* tests/converter_link_assertions.sv */
`timescale 1ns/1ps

module converter_link_assertions (
    input logic custom_srclk,
    input logic reset,
    input logic frame_load,
    input logic spi_adc_cs,
    input logic spi_dac_cs
);

    localparam int PERIOD = conv_link_pkg::FRAME_BITS;

    // Boundary strobe lasts a single cycle
    a_load_single: assert property (@(posedge custom_srclk) disable iff (reset)
        frame_load |=> !frame_load)
        else $error("frame_load high on two consecutive cycles");

    // Next boundary one full frame later
    a_load_period: assert property (@(posedge custom_srclk) disable iff (reset)
        frame_load |-> ##PERIOD frame_load)
        else $error("frame_load did not repeat after one frame");

    // Padding bits of a chip-select frame stay inactive
    a_adc_cs_pad: assert property (@(posedge custom_srclk) disable iff (reset)
        frame_load |=> spi_adc_cs ##1 spi_adc_cs ##1 spi_adc_cs ##1 spi_adc_cs)
        else $error("spi_adc_cs upper frame bits not high");

    a_dac_cs_pad: assert property (@(posedge custom_srclk) disable iff (reset)
        frame_load |=> spi_dac_cs ##1 spi_dac_cs ##1 spi_dac_cs ##1 spi_dac_cs)
        else $error("spi_dac_cs upper frame bits not high");

endmodule

/* tests/tb_converter_link.sv */
`timescale 1ns/1ps

module tb_converter_link;

    localparam int FRAME_BITS   = conv_link_pkg::FRAME_BITS;
    localparam int NUM_FRAMES   = 200;
    localparam int LOAD_TIMEOUT = 20;

    logic                         custom_srclk;
    logic                         reset;
    conv_link_pkg::cfg_write_t    cfg;
    conv_link_pkg::port_mask_t    spi_adc_sel;
    conv_link_pkg::port_mask_t    spi_dac_sel;
    logic                         custom_adc_ovf;
    logic                         custom_dirchan;
    logic                         frame_load;
    logic                         spi_adc_cs;
    logic                         spi_dac_cs;
    logic                         custom_clksel;
    logic                         custom_adc_hwcon;
    conv_link_pkg::port_status_t  port_status;

    // Reference model of the register file and the byte rotation
    conv_link_pkg::frame_word_t   model_hwcon [conv_link_pkg::NUM_PORTS];
    conv_link_pkg::port_mask_t    model_clksel;
    logic [1:0]                   model_index;

    converter_link_top #(.FRAME_BITS(FRAME_BITS)) i_dut (
        .custom_srclk     (custom_srclk),
        .reset            (reset),
        .cfg              (cfg),
        .spi_adc_sel      (spi_adc_sel),
        .spi_dac_sel      (spi_dac_sel),
        .custom_adc_ovf   (custom_adc_ovf),
        .custom_dirchan   (custom_dirchan),
        .frame_load       (frame_load),
        .spi_adc_cs       (spi_adc_cs),
        .spi_dac_cs       (spi_dac_cs),
        .custom_clksel    (custom_clksel),
        .custom_adc_hwcon (custom_adc_hwcon),
        .port_status      (port_status)
    );

    bind converter_link_top converter_link_assertions i_link_assertions (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_load   (frame_load),
        .spi_adc_cs   (spi_adc_cs),
        .spi_dac_cs   (spi_dac_cs)
    );

    initial begin
        custom_srclk = 1'b0;
        forever #5 custom_srclk = ~custom_srclk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_bit(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                    $time, what, actual, expected));
        end
    endtask

    task automatic check_word(input string what,
                              input conv_link_pkg::frame_word_t actual,
                              input conv_link_pkg::frame_word_t expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s frame is %h, expected %h",
                                    $time, what, actual, expected));
        end
    endtask

    task automatic check_status(input conv_link_pkg::port_status_t actual,
                                input conv_link_pkg::port_status_t expected);
        if (actual !== expected) begin
            stop_on_error($sformatf(
                "CHECK FAILED at %0t: port_status ovf=%h chan=%h dir=%h, expected %h %h %h",
                $time, actual.adc_ovf, actual.num_channels, actual.direction,
                expected.adc_ovf, expected.num_channels, expected.direction));
        end
    endtask

    // Inputs change 1 ns after the rising edge, outputs are read there too
    task automatic next_cycle();
        @(posedge custom_srclk);
        #1;
    endtask

    task automatic wait_frame_load();
        int waited;
        waited = 0;
        while (frame_load !== 1'b1) begin
            if (waited == LOAD_TIMEOUT) begin
                stop_on_error("Timeout: frame_load did not pulse within 20 cycles");
            end
            next_cycle();
            waited++;
        end
    endtask

    task automatic apply_model_write(input conv_link_pkg::cfg_write_t wr);
        if (wr.addr == conv_link_pkg::REG_CLKSEL) begin
            model_clksel = wr.data[3:0];
        end else begin
            model_hwcon[int'(wr.addr)] = wr.data;
        end
    endtask

    // New serial bits every cycle, a register write now and then
    task automatic drive_link_inputs(output logic ovf_bit, output logic dirchan_bit);
        conv_link_pkg::cfg_write_t wr;
        wr = '0;
        if ($urandom_range(3, 0) == 0) begin
            wr.write = 1'b1;
            wr.addr  = conv_link_pkg::cfg_reg_e'(3'($urandom_range(4, 0)));
            wr.data  = 8'($urandom);
            apply_model_write(wr);
        end
        ovf_bit        = 1'($urandom);
        dirchan_bit    = 1'($urandom);
        cfg            = wr;
        custom_adc_ovf = ovf_bit;
        custom_dirchan = dirchan_bit;
    endtask

    initial begin
        conv_link_pkg::frame_word_t   exp_adc_cs;
        conv_link_pkg::frame_word_t   exp_dac_cs;
        conv_link_pkg::frame_word_t   exp_clksel;
        conv_link_pkg::frame_word_t   exp_hwcon;
        conv_link_pkg::frame_word_t   got_adc_cs;
        conv_link_pkg::frame_word_t   got_dac_cs;
        conv_link_pkg::frame_word_t   got_clksel;
        conv_link_pkg::frame_word_t   got_hwcon;
        conv_link_pkg::frame_word_t   ovf_bits;
        conv_link_pkg::frame_word_t   dirchan_bits;
        conv_link_pkg::port_status_t  exp_status;
        logic                         ovf_bit;
        logic                         dirchan_bit;

        void'($urandom(32'ha310));
        reset          = 1'b1;
        cfg            = '0;
        spi_adc_sel    = '0;
        spi_dac_sel    = '0;
        custom_adc_ovf = 1'b0;
        custom_dirchan = 1'b0;
        for (int i = 0; i < conv_link_pkg::NUM_PORTS; i++) begin
            model_hwcon[i] = '0;
        end
        model_clksel = '0;
        model_index  = 2'd0;
        exp_status   = '0;
        got_adc_cs   = '0;
        got_dac_cs   = '0;
        got_clksel   = '0;
        got_hwcon    = '0;

        // Chip selects idle high while reset is held
        for (int i = 0; i < 5; i++) begin
            next_cycle();
            check_bit("spi_adc_cs in reset", spi_adc_cs, 1'b1);
            check_bit("spi_dac_cs in reset", spi_dac_cs, 1'b1);
            check_bit("frame_load in reset", frame_load, 1'b0);
            check_status(port_status, '0);
        end
        reset = 1'b0;

        // First strobe after the 8th edge past reset
        for (int i = 1; i <= FRAME_BITS; i++) begin
            next_cycle();
            check_bit("frame_load after reset", frame_load, i == FRAME_BITS);
        end

        for (int f = 0; f < NUM_FRAMES; f++) begin
            wait_frame_load();
            // Everything set here is what the load edge samples
            spi_adc_sel = 4'($urandom);
            spi_dac_sel = 4'($urandom);
            exp_adc_cs  = {4'hF, ~spi_adc_sel};
            exp_dac_cs  = {4'hF, ~spi_dac_sel};
            exp_clksel  = {4'h0, model_clksel};
            exp_hwcon   = model_hwcon[model_index];
            model_index = model_index + 2'd1;
            drive_link_inputs(ovf_bit, dirchan_bit);
            ovf_bits     = {7'd0, ovf_bit};
            dirchan_bits = {7'd0, dirchan_bit};

            for (int j = 0; j < FRAME_BITS; j++) begin
                next_cycle();
                check_bit("frame_load", frame_load, j == FRAME_BITS - 1);
                got_adc_cs = {got_adc_cs[FRAME_BITS-2:0], spi_adc_cs};
                got_dac_cs = {got_dac_cs[FRAME_BITS-2:0], spi_dac_cs};
                got_clksel = {got_clksel[FRAME_BITS-2:0], custom_clksel};
                got_hwcon  = {got_hwcon[FRAME_BITS-2:0], custom_adc_hwcon};
                // Status of the previous frame holds for the whole frame
                check_status(port_status, exp_status);
                if (j < FRAME_BITS - 1) begin
                    drive_link_inputs(ovf_bit, dirchan_bit);
                    ovf_bits     = {ovf_bits[FRAME_BITS-2:0], ovf_bit};
                    dirchan_bits = {dirchan_bits[FRAME_BITS-2:0], dirchan_bit};
                end
            end

            check_word("spi_adc_cs", got_adc_cs, exp_adc_cs);
            check_word("spi_dac_cs", got_dac_cs, exp_dac_cs);
            check_word("custom_clksel", got_clksel, exp_clksel);
            check_word("custom_adc_hwcon", got_hwcon, exp_hwcon);

            exp_status.adc_ovf      = ovf_bits;
            exp_status.num_channels = dirchan_bits[7:4];
            exp_status.direction    = dirchan_bits[3:0];
        end

        $display("sim passed");
        $finish;
    end

endmodule

/* src.f */
rtl/conv_link_pkg.sv
rtl/link_frame_timer.sv
rtl/link_serializer.sv
rtl/link_deserializer.sv
rtl/port_config_regs.sv
rtl/converter_link_top.sv
tests/converter_link_assertions.sv
tests/tb_converter_link.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_converter_link -o sim_tb
	out=$$(./obj_dir/sim_tb 2>&1); echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir
